/* verilog/llsc_pkg.sv */
`default_nettype none

package llsc_pkg;

	// Two requesters share one word-addressed memory.
	localparam int num_ports = 2;
	localparam int addr_width = 8;
	localparam int data_width = 32;
	localparam int mem_words = 256;

	// Reservations that can be outstanding at the same time.
	localparam int llsc_entries = 4;

	typedef enum logic [1:0] {
		op_load = 2'b00,
		op_store = 2'b01,
		op_load_locked = 2'b10,
		op_store_cond = 2'b11
	} mem_op_t;

	// Index of a requester port.
	// It is the reservation owner and the response route.
	typedef logic [$clog2(num_ports)-1:0] port_id_t;

endpackage

`default_nettype wire

/* verilog/reservation_table.sv */
`timescale 1ns/1ps
`default_nettype none

module reservation_table import llsc_pkg::*; (
	input  logic clock,
	input  logic reset,

	input  logic grant_valid,
	input  port_id_t grant_port,
	input  mem_op_t grant_op,
	input  logic [addr_width-1:0] grant_addr,

	output logic store_ok,
	output logic reserved,
	output logic full
);

	logic [llsc_entries-1:0] entry_valid;
	logic [llsc_entries-1:0] entry_good;
	port_id_t entry_owner [llsc_entries];
	logic [llsc_entries-1:0][addr_width-1:0] entry_tag;

	logic [llsc_entries-1:0] next_valid;
	logic [llsc_entries-1:0] next_good;
	port_id_t next_owner [llsc_entries];
	logic [llsc_entries-1:0][addr_width-1:0] next_tag;

	logic [llsc_entries-1:0] addr_hit;
	logic [llsc_entries-1:0] owner_hit;
	logic [llsc_entries-1:0] first_hit;
	logic [llsc_entries-1:0] first_free;
	logic owner_found;
	logic free_found;

	// A port never holds two entries for one address, since a repeated
	// load-locked renews the entry it already has.
	always_comb begin
		owner_found = 1'b0;
		free_found = 1'b0;
		for (int i = 0; i < llsc_entries; i++) begin
			addr_hit[i] = entry_valid[i] && (entry_tag[i] == grant_addr);
			owner_hit[i] = addr_hit[i] && (entry_owner[i] == grant_port);
			first_hit[i] = owner_hit[i] && !owner_found;
			owner_found = owner_found | owner_hit[i];
			first_free[i] = !entry_valid[i] && !free_found;
			free_found = free_found | !entry_valid[i];
		end
	end

	assign store_ok = grant_valid && (grant_op == op_store_cond) &&
		|(owner_hit & entry_good);

	// With the table full and no entry of its own, a load-locked reserves nothing.
	assign reserved = grant_valid && (grant_op == op_load_locked) &&
		(owner_found || free_found);

	assign full = &entry_valid;

	always_comb begin
		next_valid = entry_valid;
		next_good = entry_good;
		next_owner = entry_owner;
		next_tag = entry_tag;
		if (grant_valid) begin
			case (grant_op)
				op_load_locked: begin
					for (int i = 0; i < llsc_entries; i++) begin
						if (owner_found) begin
							if (first_hit[i]) begin
								next_good[i] = 1'b1;
							end
						end else if (first_free[i]) begin
							next_valid[i] = 1'b1;
							next_good[i] = 1'b1;
							next_owner[i] = grant_port;
							next_tag[i] = grant_addr;
						end
					end
				end
				op_store: begin
					for (int i = 0; i < llsc_entries; i++) begin
						if (addr_hit[i]) begin
							next_good[i] = 1'b0;
						end
					end
				end
				op_store_cond: begin
					// The requester's entry is released whether or not the store lands.
					for (int i = 0; i < llsc_entries; i++) begin
						if (first_hit[i]) begin
							next_valid[i] = 1'b0;
							next_good[i] = 1'b0;
						end else if (store_ok && addr_hit[i]) begin
							next_good[i] = 1'b0;
						end
					end
				end
				default: begin
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			entry_valid <= '0;
			entry_good <= '0;
		end else begin
			entry_valid <= next_valid;
			entry_good <= next_good;
		end
	end

	always_ff @(posedge clock) begin
		entry_owner <= next_owner;
		entry_tag <= next_tag;
	end

endmodule

`default_nettype wire

/* verilog/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter import llsc_pkg::*; (
	input  logic clock,
	input  logic reset,

	input  logic [num_ports-1:0] req_valid,
	input  mem_op_t req_op [num_ports],
	input  logic [num_ports-1:0][addr_width-1:0] req_addr,
	input  logic [num_ports-1:0][data_width-1:0] req_wdata,
	output logic [num_ports-1:0] req_ready,

	output logic grant_valid,
	output port_id_t grant_port,
	output mem_op_t grant_op,
	output logic [addr_width-1:0] grant_addr,
	output logic [data_width-1:0] grant_wdata
);

	// Port that has first claim on the next cycle.
	port_id_t rr_ptr;
	port_id_t next_ptr;
	port_id_t candidate;

	// Search from the pointer and take the first valid port.
	always_comb begin
		grant_valid = 1'b0;
		grant_port = rr_ptr;
		candidate = rr_ptr;
		for (int i = 0; i < num_ports; i++) begin
			candidate = port_id_t'((int'(rr_ptr) + i) % num_ports);
			if (!grant_valid && req_valid[candidate]) begin
				grant_valid = 1'b1;
				grant_port = candidate;
			end
		end
	end

	always_comb begin
		req_ready = '0;
		req_ready[grant_port] = grant_valid;
	end

	assign grant_op = req_op[grant_port];
	assign grant_addr = req_addr[grant_port];
	assign grant_wdata = req_wdata[grant_port];

	// The port after the winner gets priority next.
	always_comb begin
		if (grant_port == port_id_t'(num_ports - 1)) begin
			next_ptr = '0;
		end else begin
			next_ptr = grant_port + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			rr_ptr <= '0;
		end else if (grant_valid) begin
			rr_ptr <= next_ptr;
		end
	end

endmodule

`default_nettype wire

/* verilog/shared_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module shared_memory import llsc_pkg::*; (
	input  logic clock,
	input  logic write_enable,
	input  logic [addr_width-1:0] address,
	input  logic [data_width-1:0] write_data,
	output logic [data_width-1:0] read_data
);

	logic [data_width-1:0] mem_array [mem_words];

	always_ff @(posedge clock) begin
		if (write_enable) begin
			mem_array[address] <= write_data;
		end
	end

	// Read data shows the word as it was before a write in the same cycle.
	always_ff @(posedge clock) begin
		read_data <= mem_array[address];
	end

endmodule

`default_nettype wire

/* verilog/llsc_mem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module llsc_mem_top import llsc_pkg::*; (
	input  logic clock,
	input  logic reset,

	input  logic [num_ports-1:0] req_valid,
	input  mem_op_t req_op [num_ports],
	input  logic [num_ports-1:0][addr_width-1:0] req_addr,
	input  logic [num_ports-1:0][data_width-1:0] req_wdata,
	output logic [num_ports-1:0] req_ready,

	output logic [num_ports-1:0] resp_valid,
	output logic [num_ports-1:0][data_width-1:0] resp_rdata,
	output logic [num_ports-1:0] resp_success,

	output logic full
);

	logic grant_valid;
	port_id_t grant_port;
	mem_op_t grant_op;
	logic [addr_width-1:0] grant_addr;
	logic [data_width-1:0] grant_wdata;

	logic store_ok;
	logic reserved;
	logic write_enable;
	logic [data_width-1:0] read_data;
	logic grant_success;

	// State of the operation whose response goes out this cycle.
	logic resp_pending;
	port_id_t resp_port;
	mem_op_t resp_op;
	logic resp_success_q;
	logic resp_has_data;

	mem_arbiter i_arbiter (
		.clock(clock),
		.reset(reset),
		.req_valid(req_valid),
		.req_op(req_op),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.req_ready(req_ready),
		.grant_valid(grant_valid),
		.grant_port(grant_port),
		.grant_op(grant_op),
		.grant_addr(grant_addr),
		.grant_wdata(grant_wdata)
	);

	reservation_table i_table (
		.clock(clock),
		.reset(reset),
		.grant_valid(grant_valid),
		.grant_port(grant_port),
		.grant_op(grant_op),
		.grant_addr(grant_addr),
		.store_ok(store_ok),
		.reserved(reserved),
		.full(full)
	);

	// A store-conditional only writes while its reservation holds.
	assign write_enable = grant_valid &&
		((grant_op == op_store) || ((grant_op == op_store_cond) && store_ok));

	shared_memory i_memory (
		.clock(clock),
		.write_enable(write_enable),
		.address(grant_addr),
		.write_data(grant_wdata),
		.read_data(read_data)
	);

	always_comb begin
		case (grant_op)
			op_store: grant_success = 1'b1;
			op_store_cond: grant_success = store_ok;
			op_load_locked: grant_success = reserved;
			default: grant_success = 1'b0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			resp_pending <= 1'b0;
		end else begin
			resp_pending <= grant_valid;
		end
	end

	always_ff @(posedge clock) begin
		resp_port <= grant_port;
		resp_op <= grant_op;
		resp_success_q <= grant_success;
	end

	assign resp_has_data = (resp_op == op_load) || (resp_op == op_load_locked);

	always_comb begin
		for (int i = 0; i < num_ports; i++) begin
			resp_valid[i] = resp_pending && (resp_port == port_id_t'(i));
			resp_rdata[i] = (resp_valid[i] && resp_has_data) ? read_data : '0;
			resp_success[i] = resp_valid[i] && resp_success_q;
		end
	end

endmodule

`default_nettype wire

/* dv/llsc_mem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module llsc_mem_tb import llsc_pkg::*; ();

	localparam int max_entries = 48;

	logic clock;
	logic reset;
	logic [num_ports-1:0] req_valid;
	mem_op_t req_op [num_ports];
	logic [num_ports-1:0][addr_width-1:0] req_addr;
	logic [num_ports-1:0][data_width-1:0] req_wdata;
	logic [num_ports-1:0] req_ready;
	logic [num_ports-1:0] resp_valid;
	logic [num_ports-1:0][data_width-1:0] resp_rdata;
	logic [num_ports-1:0] resp_success;
	logic full;

	// Stimulus table. A single entry uses only the fields of tbl_port.
	string tbl_name [max_entries];
	logic tbl_both [max_entries];
	int tbl_port [max_entries];
	mem_op_t tbl_op [max_entries][num_ports];
	logic [addr_width-1:0] tbl_addr [max_entries][num_ports];
	logic [data_width-1:0] tbl_wdata [max_entries][num_ports];
	int n_entries;

	// Reference model of the memory, the reservations and the arbiter pointer.
	logic [data_width-1:0] model_mem [mem_words];
	logic rsv_valid [llsc_entries];
	logic rsv_good [llsc_entries];
	int rsv_owner [llsc_entries];
	int rsv_tag [llsc_entries];
	int model_ptr;

	integer seed;
	int error_count;
	int tests_passed;
	int tests_failed;
	int cycle_count;
	int timeout_limit;

	llsc_mem_top i_dut (
		.clock(clock),
		.reset(reset),
		.req_valid(req_valid),
		.req_op(req_op),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.req_ready(req_ready),
		.resp_valid(resp_valid),
		.resp_rdata(resp_rdata),
		.resp_success(resp_success),
		.full(full)
	);

	always #2 clock = ~clock;

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= timeout_limit) begin
			$display("timeout: the run did not finish within %0d cycles", timeout_limit);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	task automatic check_value(input string name, input string field,
			input logic [data_width-1:0] expected, input logic [data_width-1:0] actual);
		assert (actual === expected) else begin
			$display("mismatch %s %s: expected %h, actual %h", name, field, expected, actual);
			error_count++;
		end
	endtask

	task automatic require(input logic condition, input string what);
		assert (condition === 1'b1) else begin
			$display("error: %s", what);
			error_count++;
		end
	endtask

	task automatic add_single(input string name, input int port, input mem_op_t op,
			input logic [addr_width-1:0] addr);
		tbl_name[n_entries] = name;
		tbl_both[n_entries] = 1'b0;
		tbl_port[n_entries] = port;
		for (int p = 0; p < num_ports; p++) begin
			tbl_op[n_entries][p] = op;
			tbl_addr[n_entries][p] = addr;
			tbl_wdata[n_entries][p] = $random(seed);
		end
		n_entries++;
	endtask

	task automatic add_pair(input string name, input mem_op_t op0,
			input logic [addr_width-1:0] addr0, input mem_op_t op1,
			input logic [addr_width-1:0] addr1);
		tbl_name[n_entries] = name;
		tbl_both[n_entries] = 1'b1;
		tbl_port[n_entries] = 0;
		tbl_op[n_entries][0] = op0;
		tbl_addr[n_entries][0] = addr0;
		tbl_wdata[n_entries][0] = $random(seed);
		tbl_op[n_entries][1] = op1;
		tbl_addr[n_entries][1] = addr1;
		tbl_wdata[n_entries][1] = $random(seed);
		n_entries++;
	endtask

	function automatic logic model_full();
		logic all_valid;
		all_valid = 1'b1;
		for (int i = 0; i < llsc_entries; i++) begin
			all_valid = all_valid & rsv_valid[i];
		end
		return all_valid;
	endfunction

	// Clears the good bit of every reservation on the address.
	task automatic model_cancel(input int addr);
		for (int i = 0; i < llsc_entries; i++) begin
			if (rsv_valid[i] && rsv_tag[i] == addr) begin
				rsv_good[i] = 1'b0;
			end
		end
	endtask

	task automatic model_apply(input int port, input mem_op_t op, input int addr,
			input logic [data_width-1:0] wdata, output logic [data_width-1:0] rdata,
			output logic success);
		int own;
		int slot;
		own = -1;
		slot = -1;
		rdata = '0;
		success = 1'b0;
		for (int i = 0; i < llsc_entries; i++) begin
			if (own < 0 && rsv_valid[i] && rsv_owner[i] == port && rsv_tag[i] == addr) begin
				own = i;
			end
			if (slot < 0 && !rsv_valid[i]) begin
				slot = i;
			end
		end
		case (op)
			op_load: begin
				rdata = model_mem[addr];
			end
			op_store: begin
				model_mem[addr] = wdata;
				model_cancel(addr);
				success = 1'b1;
			end
			op_load_locked: begin
				rdata = model_mem[addr];
				if (own >= 0) begin
					rsv_good[own] = 1'b1;
					success = 1'b1;
				end else if (slot >= 0) begin
					rsv_valid[slot] = 1'b1;
					rsv_good[slot] = 1'b1;
					rsv_owner[slot] = port;
					rsv_tag[slot] = addr;
					success = 1'b1;
				end
			end
			op_store_cond: begin
				if (own >= 0) begin
					success = rsv_good[own];
					rsv_valid[own] = 1'b0;
					rsv_good[own] = 1'b0;
				end
				if (success) begin
					model_mem[addr] = wdata;
					model_cancel(addr);
				end
			end
		endcase
	endtask

	task automatic build_table();
		// Port 0 has priority in the first arbitration after reset.
		add_pair("pair_store_a10_a11", op_store, 8'h10, op_store, 8'h11);
		add_single("load_p1_a10", 1, op_load, 8'h10);
		add_single("load_p0_a11", 0, op_load, 8'h11);
		add_single("store_p0_a20", 0, op_store, 8'h20);
		add_single("ll_p0_a20", 0, op_load_locked, 8'h20);
		add_single("sc_p0_a20_ok", 0, op_store_cond, 8'h20);
		add_single("load_p1_a20", 1, op_load, 8'h20);
		add_single("store_p0_a30", 0, op_store, 8'h30);
		add_single("ll_p0_a30", 0, op_load_locked, 8'h30);
		add_single("store_p1_a30", 1, op_store, 8'h30);
		add_single("sc_p0_a30_cancelled", 0, op_store_cond, 8'h30);
		add_single("load_p0_a30", 0, op_load, 8'h30);
		add_single("store_p1_a40", 1, op_store, 8'h40);
		add_single("ll_p0_a40", 0, op_load_locked, 8'h40);
		add_single("ll_p1_a40", 1, op_load_locked, 8'h40);
		add_single("sc_p1_a40_first", 1, op_store_cond, 8'h40);
		add_single("sc_p0_a40_second", 0, op_store_cond, 8'h40);
		add_single("sc_p0_a41_unreserved", 0, op_store_cond, 8'h41);
		add_single("load_p0_a40", 0, op_load, 8'h40);
		// Fill four entries, overflow the table, then drain it.
		add_pair("pair_store_a50_a51", op_store, 8'h50, op_store, 8'h51);
		add_pair("pair_store_a52_a53", op_store, 8'h52, op_store, 8'h53);
		add_single("store_p1_a54", 1, op_store, 8'h54);
		add_single("ll_p0_a50", 0, op_load_locked, 8'h50);
		add_single("ll_p1_a51", 1, op_load_locked, 8'h51);
		add_single("ll_p0_a52", 0, op_load_locked, 8'h52);
		add_single("ll_p1_a53", 1, op_load_locked, 8'h53);
		add_single("ll_p0_a54_full", 0, op_load_locked, 8'h54);
		add_single("sc_p0_a54_none", 0, op_store_cond, 8'h54);
		add_single("sc_p0_a50", 0, op_store_cond, 8'h50);
		add_single("sc_p1_a51", 1, op_store_cond, 8'h51);
		add_single("sc_p0_a52", 0, op_store_cond, 8'h52);
		add_single("sc_p1_a53", 1, op_store_cond, 8'h53);
		add_pair("pair_store_a60_a61", op_store, 8'h60, op_store, 8'h61);
		add_pair("pair_load_a61_a60", op_load, 8'h61, op_load, 8'h60);
		add_pair("pair_store_same_a62", op_store, 8'h62, op_store, 8'h62);
		add_single("load_p0_a62", 0, op_load, 8'h62);
		add_pair("pair_ll_a62", op_load_locked, 8'h62, op_load_locked, 8'h62);
		add_pair("pair_sc_a62", op_store_cond, 8'h62, op_store_cond, 8'h62);
		add_single("load_p1_a62", 1, op_load, 8'h62);
	endtask

	task automatic run_entry(input int idx);
		logic [num_ports-1:0] issue;
		logic [num_ports-1:0] accepted;
		logic [num_ports-1:0] answered;
		int accept_iter [num_ports];
		logic [data_width-1:0] got_rdata [num_ports];
		logic got_success [num_ports];
		logic [data_width-1:0] exp_rdata;
		logic exp_success;
		int first_port;
		int exp_first;
		int iter;
		int errors_before;
		int p;
		string name;
		name = tbl_name[idx];
		errors_before = error_count;
		issue = tbl_both[idx] ? '1 : num_ports'(1 << tbl_port[idx]);
		accepted = '0;
		answered = '0;
		first_port = -1;
		@(posedge clock);
		#0.5;
		for (int q = 0; q < num_ports; q++) begin
			if (issue[q]) begin
				req_valid[q] = 1'b1;
				req_op[q] = tbl_op[idx][q];
				req_addr[q] = tbl_addr[idx][q];
				req_wdata[q] = tbl_wdata[idx][q];
			end
		end
		iter = 0;
		while (answered != issue && iter < 8) begin
			@(negedge clock);
			require($countones(req_ready) <= 1, $sformatf("%s: more than one port ready", name));
			for (int q = 0; q < num_ports; q++) begin
				if (resp_valid[q]) begin
					require(accepted[q] && !answered[q] && iter == accept_iter[q] + 1,
						$sformatf("%s: response on port %0d in the wrong cycle", name, q));
					got_rdata[q] = resp_rdata[q];
					got_success[q] = resp_success[q];
					answered[q] = 1'b1;
				end
			end
			for (int q = 0; q < num_ports; q++) begin
				if (req_valid[q] && req_ready[q]) begin
					accepted[q] = 1'b1;
					accept_iter[q] = iter;
					if (first_port < 0) begin
						first_port = q;
					end
				end
			end
			@(posedge clock);
			#0.5;
			for (int q = 0; q < num_ports; q++) begin
				if (accepted[q]) begin
					req_valid[q] = 1'b0;
				end
			end
			iter++;
		end
		require(answered == issue, $sformatf("%s: a port got no response", name));
		req_valid = '0;

		// Replay the operations in the order the arbiter should grant them.
		exp_first = tbl_both[idx] ? model_ptr : tbl_port[idx];
		if (tbl_both[idx]) begin
			check_value(name, "first grant", exp_first, first_port);
		end
		p = exp_first;
		for (int k = 0; k < num_ports; k++) begin
			if (issue[p]) begin
				model_apply(p, tbl_op[idx][p], tbl_addr[idx][p], tbl_wdata[idx][p],
					exp_rdata, exp_success);
				model_ptr = (p + 1) % num_ports;
				if (answered[p]) begin
					check_value(name, $sformatf("port %0d rdata", p), exp_rdata, got_rdata[p]);
					check_value(name, $sformatf("port %0d success", p), exp_success,
						got_success[p]);
				end
			end
			p = (p + 1) % num_ports;
		end

		// Responses last one cycle, so nothing is valid after the last one.
		@(negedge clock);
		require(resp_valid == '0, $sformatf("%s: response held for more than one cycle", name));
		check_value(name, "full", model_full(), full);

		if (error_count == errors_before) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: failed", name);
		end
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		req_valid = '0;
		req_addr = '0;
		req_wdata = '0;
		for (int q = 0; q < num_ports; q++) begin
			req_op[q] = op_load;
		end
		seed = 32'h5d14;
		error_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		cycle_count = 0;
		n_entries = 0;
		model_ptr = 0;
		for (int i = 0; i < llsc_entries; i++) begin
			rsv_valid[i] = 1'b0;
			rsv_good[i] = 1'b0;
			rsv_owner[i] = 0;
			rsv_tag[i] = 0;
		end
		build_table();
		timeout_limit = n_entries * 10 + 50;

		repeat (2) @(posedge clock);
		#0.5;
		reset = 1'b0;
		@(negedge clock);
		require(req_ready == '0 && resp_valid == '0 && full == 1'b0,
			"outputs are not idle after reset");

		for (int idx = 0; idx < n_entries; idx++) begin
			run_entry(idx);
		end

		$display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
			n_entries, tests_passed, tests_failed, error_count);
		if (error_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
verilog/llsc_pkg.sv
verilog/reservation_table.sv
verilog/mem_arbiter.sv
verilog/shared_memory.sv
verilog/llsc_mem_top.sv
dv/llsc_mem_tb.sv

/* Bender.yml */
package:
  name: llsc_mem

sources:
  # Design sources in compile order.
  - files:
      - verilog/llsc_pkg.sv
      - verilog/reservation_table.sv
      - verilog/mem_arbiter.sv
      - verilog/shared_memory.sv
      - verilog/llsc_mem_top.sv

  # Testbench, built only for simulation.
  - target: test
    files:
      - dv/llsc_mem_tb.sv
